// File: build.f
hw/noc_pkg.sv
hw/kernel_pkg.sv
hw/leaf_unpacker.sv
hw/user_kernel.sv
hw/out_port_packer.sv
hw/leaf_arbiter.sv
hw/leaf_node.sv
test/leaf_node_properties.sv
test/tb_leaf_node.sv

// File: Bender.yml
package:
  name: leaf_node

sources:
  - hw/noc_pkg.sv
  - hw/kernel_pkg.sv
  - hw/leaf_unpacker.sv
  - hw/user_kernel.sv
  - hw/out_port_packer.sv
  - hw/leaf_arbiter.sv
  - hw/leaf_node.sv
  - target: test
    files:
      - test/leaf_node_properties.sv
      - test/tb_leaf_node.sv

// File: test/tb_leaf_node.sv
module tb_leaf_node;

    localparam logic [noc_pkg::leaf_bits-1:0] leaf_id = 3;
    localparam int test_cycles = 300; // reset, configuration and about a dozen pairs of 20 cycles.
    localparam int cycle_limit = 2 * test_cycles;

    logic                            clk;
    logic                            arst_n;
    logic [noc_pkg::packet_bits-1:0] din_leaf_bft2interface;
    logic [noc_pkg::packet_bits-1:0] dout_leaf_interface2bft;
    logic                            overflow;

    logic [noc_pkg::packet_bits-1:0] expected [$];
    logic [noc_pkg::dest_bits-1:0]   dest [kernel_pkg::num_out_streams];
    logic [noc_pkg::addr_bits-1:0]   seq [kernel_pkg::num_out_streams];
    integer seed = 32'hc4f2;
    int     cycles = 0;

    leaf_node #(.leaf_id(leaf_id)) uut (
        .clk(clk),
        .arst_n(arst_n),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .dout_leaf_interface2bft(dout_leaf_interface2bft),
        .overflow(overflow)
    );

    always #20 clk = ~clk;

    // ==============================
    // reference and helpers
    // ==============================

    function automatic logic [31:0] expected_result(input int op, input logic [31:0] a,
                                                    input logic [31:0] b);
        case (kernel_pkg::kernel_op_e'(op))
            kernel_pkg::op_add: return a + b;
            kernel_pkg::op_sub: return a - b;
            kernel_pkg::op_and: return a & b;
            kernel_pkg::op_or:  return a | b;
            kernel_pkg::op_xor: return a ^ b;
            default:            return (a > b) ? a : b; // unsigned maximum.
        endcase
    endfunction

    function automatic logic [48:0] make_packet(input logic [4:0] leaf, input logic [3:0] port,
                                                input logic [6:0] addr, input logic [31:0] data);
        return {1'b1, leaf, port, addr, data};
    endfunction

    task automatic check(input string name, input logic [48:0] got, input logic [48:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic send_packet(input logic [48:0] pkt);
        @(posedge clk);
        #2 din_leaf_bft2interface = pkt;
        @(posedge clk);
        #2 din_leaf_bft2interface = '0;
    endtask

    task automatic configure(input int j, input logic [8:0] d);
        dest[j] = d;
        send_packet(make_packet(leaf_id, noc_pkg::cfg_port, 7'(j), {23'b0, d}));
    endtask

    // one packet per output stream, in the order the streams will send them.
    task automatic queue_results(input logic [31:0] a, input logic [31:0] b);
        for (int j = 0; j < kernel_pkg::num_out_streams; j++) begin
            expected.push_back({1'b1, dest[j], seq[j], expected_result(j, a, b)});
            seq[j] = seq[j] + 1'b1;
        end
    endtask

    task automatic send_pair(input logic [31:0] a, input logic [31:0] b);
        queue_results(a, b);
        send_packet(make_packet(leaf_id, 4'd1, 7'd0, a));
        send_packet(make_packet(leaf_id, 4'd2, 7'd0, b));
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) @(posedge clk);
    endtask

    // ==============================
    // checking and timeout
    // ==============================

    always @(negedge clk) begin : monitor
        int hit;
        hit = -1;
        if (arst_n && dout_leaf_interface2bft[noc_pkg::valid_pos]) begin
            for (int k = 0; k < expected.size(); k++) begin
                if (hit < 0 && expected[k][noc_pkg::port_lsb +: noc_pkg::port_bits]
                        == dout_leaf_interface2bft[noc_pkg::port_lsb +: noc_pkg::port_bits]) begin
                    hit = k;
                end
            end
            if (hit < 0) begin
                $display("unexpected packet %h on the output link at %0t",
                         dout_leaf_interface2bft, $time);
                $display("Simulation FAILED");
                $fatal(1, "unexpected packet");
            end else begin
                check("dout_leaf_interface2bft", dout_leaf_interface2bft, expected[hit]);
                expected.delete(hit);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: results still missing after %0d cycles", cycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // ==============================
    // stimulus
    // ==============================

    initial begin
        logic [31:0] w [3];
        logic [31:0] b0;
        logic [31:0] b1;
        clk = 1'b0;
        arst_n = 1'b0;
        din_leaf_bft2interface = '0;
        for (int j = 0; j < kernel_pkg::num_out_streams; j++) begin
            dest[j] = '0;
            seq[j] = '0;
        end
        repeat (16) @(posedge clk);
        #2 arst_n = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check("dout_leaf_interface2bft", dout_leaf_interface2bft, '0);
            check("overflow", overflow, 1'b0);
        end

        for (int j = 0; j < kernel_pkg::num_out_streams; j++) configure(j, {5'(8 + j), 4'(j + 1)});
        send_pair($random(seed), $random(seed));
        wait_drain();
        repeat (6) begin
            send_pair($random(seed), $random(seed));
            wait_drain();
        end

        // another leaf, then a port above 2. neither may disturb the counts.
        send_packet(make_packet(leaf_id + 1'b1, 4'd1, 7'd0, $random(seed)));
        send_packet(make_packet(leaf_id, 4'd5, 7'd2, $random(seed)));
        repeat (10) @(posedge clk);
        send_pair($random(seed), $random(seed));
        wait_drain();

        for (int k = 0; k < 3; k++) begin
            w[k] = $random(seed);
            send_packet(make_packet(leaf_id, 4'd1, 7'd0, w[k])); // the third one is dropped.
        end
        @(negedge clk);
        check("overflow", overflow, 1'b1);
        b0 = $random(seed);
        b1 = $random(seed);
        queue_results(w[0], b0);
        queue_results(w[1], b1);
        send_packet(make_packet(leaf_id, 4'd2, 7'd0, b0));
        send_packet(make_packet(leaf_id, 4'd2, 7'd0, b1));
        wait_drain();

        configure(3, {5'd20, 4'd9});
        send_pair($random(seed), $random(seed));
        wait_drain();

        repeat (5) @(posedge clk);
        if (expected.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "results left over");
        end
    end

endmodule

// File: test/leaf_node_properties.sv
module leaf_node_properties (
    input logic                                   clk,
    input logic                                   arst_n,
    input logic [noc_pkg::packet_bits-1:0]        dout,
    input logic                                   overflow,
    input logic [kernel_pkg::num_out_streams-1:0] vld,
    input logic [kernel_pkg::num_out_streams-1:0] ack
);

    // an idle link carries no stray bits.
    a_dout_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !dout[noc_pkg::valid_pos] |-> dout == '0)
        else $error("output link not zero without its valid bit");

    a_overflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        overflow |=> overflow)
        else $error("overflow fell while out of reset");

    for (genvar j = 0; j < kernel_pkg::num_out_streams; j++) begin : g_hold
        a_vld_hold: assert property (@(posedge clk) disable iff (!arst_n)
            vld[j] && !ack[j] |=> vld[j])
            else $error("kernel result dropped before its ack");
    end

endmodule

bind leaf_node leaf_node_properties props_inst (
    .clk(clk),
    .arst_n(arst_n),
    .dout(dout_leaf_interface2bft),
    .overflow(overflow),
    .vld(vld_user2interface),
    .ack(ack_interface2user)
);

// File: hw/leaf_node.sv
module leaf_node #(
    parameter logic [noc_pkg::leaf_bits-1:0] leaf_id = 3
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [noc_pkg::packet_bits-1:0] din_leaf_bft2interface,
    output logic [noc_pkg::packet_bits-1:0] dout_leaf_interface2bft,
    output logic                           overflow
);

    logic [kernel_pkg::num_in_streams-1:0][noc_pkg::payload_bits-1:0] dout_leaf_interface2user;
    logic [kernel_pkg::num_in_streams-1:0]  vld_interface2user;
    logic [kernel_pkg::num_in_streams-1:0]  ack_user2interface;

    logic [kernel_pkg::num_out_streams-1:0][noc_pkg::payload_bits-1:0] din_leaf_user2interface;
    logic [kernel_pkg::num_out_streams-1:0] vld_user2interface;
    logic [kernel_pkg::num_out_streams-1:0] ack_interface2user;

    logic [kernel_pkg::num_out_streams-1:0] cfg_we;
    logic [noc_pkg::dest_bits-1:0]          cfg_data;

    logic [kernel_pkg::num_out_streams-1:0][noc_pkg::packet_bits-1:0] pkt;
    logic [kernel_pkg::num_out_streams-1:0] pkt_ready;
    logic [kernel_pkg::num_out_streams-1:0] pkt_take;

    leaf_unpacker #(
        .leaf_id(leaf_id)
    ) unpacker_inst (
        .clk(clk),
        .arst_n(arst_n),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user(vld_interface2user),
        .ack_user2interface(ack_user2interface),
        .cfg_we(cfg_we),
        .cfg_data(cfg_data),
        .overflow(overflow)
    );

    user_kernel kernel_inst (
        .clk(clk),
        .arst_n(arst_n),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user(vld_interface2user),
        .ack_user2interface(ack_user2interface),
        .din_leaf_user2interface(din_leaf_user2interface),
        .vld_user2interface(vld_user2interface),
        .ack_interface2user(ack_interface2user)
    );

    // one packer per kernel output stream.
    for (genvar j = 0; j < kernel_pkg::num_out_streams; j++) begin : g_out
        out_port_packer packer_inst (
            .clk(clk),
            .arst_n(arst_n),
            .din(din_leaf_user2interface[j]),
            .vld(vld_user2interface[j]),
            .ack(ack_interface2user[j]),
            .cfg_we(cfg_we[j]),
            .cfg_data(cfg_data),
            .pkt(pkt[j]),
            .pkt_ready(pkt_ready[j]),
            .pkt_take(pkt_take[j])
        );
    end

    leaf_arbiter arbiter_inst (
        .clk(clk),
        .arst_n(arst_n),
        .pkt(pkt),
        .pkt_ready(pkt_ready),
        .pkt_take(pkt_take),
        .dout_leaf_interface2bft(dout_leaf_interface2bft)
    );

endmodule

// File: hw/leaf_arbiter.sv
module leaf_arbiter (
    input  logic clk,
    input  logic arst_n,
    input  logic [kernel_pkg::num_out_streams-1:0][noc_pkg::packet_bits-1:0] pkt,
    input  logic [kernel_pkg::num_out_streams-1:0] pkt_ready,
    output logic [kernel_pkg::num_out_streams-1:0] pkt_take,
    output logic [noc_pkg::packet_bits-1:0]        dout_leaf_interface2bft
);

    typedef logic [$clog2(kernel_pkg::num_out_streams)-1:0] sel_t;

    sel_t last;
    sel_t grant_idx;
    logic grant_vld;

    // ==============================
    // round-robin search
    // ==============================

    // the search starts just after the packer served last.
    always_comb begin
        int idx;
        grant_idx = '0;
        grant_vld = 1'b0;
        for (int k = 1; k <= kernel_pkg::num_out_streams; k++) begin
            idx = (int'(last) + k) % kernel_pkg::num_out_streams;
            if (!grant_vld && pkt_ready[idx]) begin
                grant_vld = 1'b1;
                grant_idx = sel_t'(idx);
            end
        end
    end

    always_comb begin
        pkt_take = '0;
        if (grant_vld) begin
            pkt_take[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last                    <= sel_t'(kernel_pkg::num_out_streams - 1);
            dout_leaf_interface2bft <= '0;
        end else begin
            dout_leaf_interface2bft <= grant_vld ? pkt[grant_idx] : '0; // idle link is all zeros.
            if (grant_vld) begin
                last <= grant_idx;
            end
        end
    end

endmodule

// File: hw/out_port_packer.sv
module out_port_packer (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [noc_pkg::payload_bits-1:0] din,
    input  logic                            vld,
    output logic                            ack,
    input  logic                            cfg_we,
    input  logic [noc_pkg::dest_bits-1:0]    cfg_data,
    output logic [noc_pkg::packet_bits-1:0]  pkt,
    output logic                            pkt_ready,
    input  logic                            pkt_take
);

    logic [noc_pkg::dest_bits-1:0] dest;
    logic [noc_pkg::addr_bits-1:0] seq;
    logic                          accept;
    logic                          ready_next;

    assign accept     = vld && ack;
    assign ready_next = (pkt_ready && !pkt_take) || accept;

    // ack is high exactly while the slot is empty, apart from the first cycle after reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_ready <= 1'b0;
            ack       <= 1'b0;
            seq       <= '0;
            dest      <= '0;
        end else begin
            pkt_ready <= ready_next;
            ack       <= !ready_next;
            if (accept) begin
                seq <= seq + 1'b1; // wraps at 128.
            end
            if (cfg_we) begin
                dest <= cfg_data;
            end
        end
    end

    // ==============================
    // packet slot
    // ==============================

    // valid bit, then leaf and port, then the sequence number as address.
    always_ff @(posedge clk) begin
        if (accept) begin
            pkt <= {1'b1, dest, seq, din};
        end
    end

endmodule

// File: hw/user_kernel.sv
module user_kernel (
    input  logic clk,
    input  logic arst_n,
    input  logic [kernel_pkg::num_in_streams-1:0][noc_pkg::payload_bits-1:0]
                 dout_leaf_interface2user,
    input  logic [kernel_pkg::num_in_streams-1:0] vld_interface2user,
    output logic [kernel_pkg::num_in_streams-1:0] ack_user2interface,
    output logic [kernel_pkg::num_out_streams-1:0][noc_pkg::payload_bits-1:0]
                 din_leaf_user2interface,
    output logic [kernel_pkg::num_out_streams-1:0] vld_user2interface,
    input  logic [kernel_pkg::num_out_streams-1:0] ack_interface2user
);

    kernel_pkg::kernel_state_e state;

    logic                                   go;
    logic [kernel_pkg::num_out_streams-1:0] remaining;

    function automatic logic [noc_pkg::payload_bits-1:0] calc(
        input kernel_pkg::kernel_op_e          op,
        input logic [noc_pkg::payload_bits-1:0] a,
        input logic [noc_pkg::payload_bits-1:0] b
    );
        unique case (op)
            kernel_pkg::op_add: return a + b;
            kernel_pkg::op_sub: return a - b;
            kernel_pkg::op_and: return a & b;
            kernel_pkg::op_or:  return a | b;
            kernel_pkg::op_xor: return a ^ b;
            kernel_pkg::op_max: return (a > b) ? a : b;
            default:            return '0;
        endcase
    endfunction

    // both operands present. in st_wait every output stream is already idle.
    assign go = (state == kernel_pkg::st_wait) && (&vld_interface2user);

    assign ack_user2interface = {kernel_pkg::num_in_streams{go}}; // pop both streams together.

    assign remaining = vld_user2interface & ~ack_interface2user;

    // ==============================
    // control
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state              <= kernel_pkg::st_wait;
            vld_user2interface <= '0;
        end else begin
            unique case (state)
                kernel_pkg::st_wait: begin
                    if (go) begin
                        state              <= kernel_pkg::st_emit;
                        vld_user2interface <= '1;
                    end
                end
                kernel_pkg::st_emit: begin
                    vld_user2interface <= remaining; // each stream drops after its ack.
                    if (remaining == '0) begin
                        state <= kernel_pkg::st_wait;
                    end
                end
                default: state <= kernel_pkg::st_wait;
            endcase
        end
    end

    // ==============================
    // datapath
    // ==============================

    // results are computed once, at the cycle that pops the operands.
    always_ff @(posedge clk) begin
        if (go) begin
            for (int j = 0; j < kernel_pkg::num_out_streams; j++) begin
                din_leaf_user2interface[j] <= calc(kernel_pkg::kernel_op_e'(j),
                                                   dout_leaf_interface2user[0],
                                                   dout_leaf_interface2user[1]);
            end
        end
    end

endmodule

// File: hw/leaf_unpacker.sv
module leaf_unpacker #(
    parameter logic [noc_pkg::leaf_bits-1:0] leaf_id = '0
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [noc_pkg::packet_bits-1:0]     din_leaf_bft2interface,
    output logic [kernel_pkg::num_in_streams-1:0][noc_pkg::payload_bits-1:0]
                                                dout_leaf_interface2user,
    output logic [kernel_pkg::num_in_streams-1:0] vld_interface2user,
    input  logic [kernel_pkg::num_in_streams-1:0] ack_user2interface,
    output logic [kernel_pkg::num_out_streams-1:0] cfg_we,
    output logic [noc_pkg::dest_bits-1:0]       cfg_data,
    output logic                                overflow
);

    logic [noc_pkg::leaf_bits-1:0]    leaf;
    logic [noc_pkg::port_bits-1:0]    port;
    logic [noc_pkg::addr_bits-1:0]    addr;
    logic [noc_pkg::payload_bits-1:0] payload;
    logic                             for_me;
    logic                             is_cfg;
    logic [kernel_pkg::num_in_streams-1:0] drop;

    assign leaf    = din_leaf_bft2interface[noc_pkg::leaf_lsb +: noc_pkg::leaf_bits];
    assign port    = din_leaf_bft2interface[noc_pkg::port_lsb +: noc_pkg::port_bits];
    assign addr    = din_leaf_bft2interface[noc_pkg::addr_lsb +: noc_pkg::addr_bits];
    assign payload = din_leaf_bft2interface[noc_pkg::payload_bits-1:0];

    assign for_me = din_leaf_bft2interface[noc_pkg::valid_pos] && (leaf == leaf_id);
    assign is_cfg = for_me && (port == noc_pkg::cfg_port)
                    && (addr < kernel_pkg::num_out_streams);

    // ==============================
    // configuration writes
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_we <= '0;
        end else begin
            for (int j = 0; j < kernel_pkg::num_out_streams; j++) begin
                cfg_we[j] <= is_cfg && (addr == j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_cfg) begin
            cfg_data <= payload[noc_pkg::dest_bits-1:0];
        end
    end

    // ==============================
    // input stream buffers
    // ==============================

    for (genvar i = 0; i < kernel_pkg::num_in_streams; i++) begin : g_in
        logic [noc_pkg::payload_bits-1:0]              mem [kernel_pkg::in_buf_depth];
        logic [$clog2(kernel_pkg::in_buf_depth)-1:0]   wr_ptr;
        logic [$clog2(kernel_pkg::in_buf_depth)-1:0]   rd_ptr;
        logic [$clog2(kernel_pkg::in_buf_depth+1)-1:0] count;
        logic push;
        logic push_ok;
        logic pop;
        logic full;

        assign push    = for_me && (port == noc_pkg::first_in_port + i);
        assign full    = (count == kernel_pkg::in_buf_depth);
        assign push_ok = push && !full;
        assign pop     = ack_user2interface[i] && (count != '0);
        assign drop[i] = push && full; // the word is lost.

        assign vld_interface2user[i]       = (count != '0);
        assign dout_leaf_interface2user[i] = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (push_ok) begin
                mem[wr_ptr] <= payload;
            end
        end

        // pointers wrap on their own since the depth is a power of two.
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push_ok) wr_ptr <= wr_ptr + 1'b1;
                if (pop) rd_ptr <= rd_ptr + 1'b1;
                unique case ({push_ok, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else if (|drop) begin
            overflow <= 1'b1; // sticky until reset.
        end
    end

endmodule

// File: hw/kernel_pkg.sv
package kernel_pkg;

    // ==============================
    // kernel stream layout
    // ==============================

    localparam int num_in_streams  = 2;
    localparam int num_out_streams = 6;

    // words held per input stream. keep this a power of two.
    localparam int in_buf_depth = 2;

    // output stream j computes with opcode value j.
    typedef enum logic [2:0] {
        op_add,
        op_sub, // first operand minus second.
        op_and,
        op_or,
        op_xor,
        op_max  // unsigned maximum.
    } kernel_op_e;

    typedef enum logic {
        st_wait,
        st_emit
    } kernel_state_e;

endpackage

// File: hw/noc_pkg.sv
package noc_pkg;

    // ==============================
    // tree link packet format
    // ==============================

    // a packet is, from the top bit down:
    // valid, destination leaf, destination port, address, payload.
    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int addr_bits    = 7;

    // the destination that an output stream is programmed with is leaf and port together.
    localparam int dest_bits = leaf_bits + port_bits;

    localparam int valid_pos = 48; // set on every real packet.
    localparam int leaf_lsb  = 43; // leaf occupies 47:43.
    localparam int port_lsb  = 39; // port occupies 42:39.
    localparam int addr_lsb  = 32; // address occupies 38:32.

    // ==============================
    // port numbering
    // ==============================

    // port 0 carries configuration writes for the output streams.
    localparam int cfg_port = 0;

    // data ports start here. port first_in_port + i feeds input stream i.
    localparam int first_in_port = 1;

endpackage
